//--- compile.f
+incdir+hdl
hdl/iob_timer_pkg.sv
hdl/axil2iob.sv
hdl/timer_regs.sv
hdl/timer_core.sv
hdl/iob_timer_top.sv
test/tb_iob_timer.sv

//--- hdl/axil2iob.sv
`timescale 1ns/1ps
`default_nettype none

`include "iob_timer_params.svh"

module axil2iob (
   input  logic                     clk,
   input  logic                     rst,

   // AXI4-Lite write address
   input  iob_timer_pkg::addr_t     s_axil_awaddr,
   input  logic                     s_axil_awvalid,
   output logic                     s_axil_awready,

   // AXI4-Lite write data
   input  iob_timer_pkg::data_t     s_axil_wdata,
   input  iob_timer_pkg::strb_t     s_axil_wstrb,
   input  logic                     s_axil_wvalid,
   output logic                     s_axil_wready,

   // AXI4-Lite write response
   output logic [`AXI_ID_W-1:0]     s_axil_bid,
   output logic [`AXI_RESP_W-1:0]   s_axil_bresp,
   output logic                     s_axil_bvalid,
   input  logic                     s_axil_bready,

   // AXI4-Lite read address
   input  iob_timer_pkg::addr_t     s_axil_araddr,
   input  logic                     s_axil_arvalid,
   output logic                     s_axil_arready,

   // AXI4-Lite read data
   output logic [`AXI_ID_W-1:0]     s_axil_rid,
   output iob_timer_pkg::data_t     s_axil_rdata,
   output logic [`AXI_RESP_W-1:0]   s_axil_rresp,
   output logic                     s_axil_rvalid,
   input  logic                     s_axil_rready,

   // Native master side
   output logic                     valid,
   output iob_timer_pkg::addr_t     addr,
   output iob_timer_pkg::data_t     wdata,
   output iob_timer_pkg::strb_t     wstrb,
   input  iob_timer_pkg::data_t     rdata,
   input  logic                     ready
);

   import iob_timer_pkg::*;

   bridge_state_t state;
   bridge_state_t state_nxt;

   // Remembers that read data came back while rready was low
   logic ready_hold;

   // Single ID, always OKAY
   assign s_axil_bid   = '0;
   assign s_axil_rid   = '0;
   assign s_axil_bresp = '0;
   assign s_axil_rresp = '0;

   assign s_axil_rdata = rdata;

   // Write channel wins the address while W is presented
   assign addr  = s_axil_wvalid ? s_axil_awaddr : s_axil_araddr;
   assign wstrb = s_axil_wvalid ? s_axil_wstrb : '0;
   assign wdata = s_axil_wdata;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready_hold <= 1'b0;
      end else if (state_nxt == IDLE) begin
         ready_hold <= 1'b0;
      end else if (state == READ && ready) begin
         ready_hold <= 1'b1;
      end
   end

   always_comb begin
      state_nxt      = state;
      valid          = 1'b0;
      s_axil_awready = 1'b0;
      s_axil_wready  = 1'b0;
      s_axil_arready = 1'b0;
      s_axil_bvalid  = 1'b0;
      s_axil_rvalid  = 1'b0;

      case (state)
         IDLE: begin
            // AW and W arrive together
            if (s_axil_awvalid && s_axil_wvalid) begin
               state_nxt = WRITE;
            end else if (s_axil_arvalid) begin
               state_nxt = READ;
            end
         end
         WRITE: begin
            valid          = ~ready;
            s_axil_awready = ready;
            s_axil_wready  = ready;
            if (ready) begin
               state_nxt = W_RESPONSE;
            end
         end
         READ: begin
            valid          = ~(ready | ready_hold);
            s_axil_arready = ready & s_axil_arvalid;
            s_axil_rvalid  = ready | ready_hold;
            if ((ready || ready_hold) && s_axil_rready) begin
               state_nxt = IDLE;
            end
         end
         W_RESPONSE: begin
            s_axil_bvalid = 1'b1;
            if (s_axil_bready) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   // Read data holds while the master stalls
   a_rvalid_held: assert property (
      @(posedge clk) disable iff (rst)
      (s_axil_rvalid && !s_axil_rready) |=> (s_axil_rvalid && $stable(s_axil_rdata))
   );

   // Register block answers the cycle after a request
   a_valid_answered: assert property (
      @(posedge clk) disable iff (rst)
      valid |=> ready
   );

endmodule

`default_nettype wire

//--- hdl/iob_timer_params.svh
`ifndef IOB_TIMER_PARAMS_SVH
`define IOB_TIMER_PARAMS_SVH

// Native bus and AXI4-Lite widths
`define IOB_ADDR_W 32
`define IOB_DATA_W 32
`define IOB_STRB_W (`IOB_DATA_W / 8)

`define AXI_RESP_W 2
`define AXI_ID_W 1

// Register map
`define TMR_CTRL_ADDR   `IOB_ADDR_W'h0
`define TMR_LOAD_ADDR   `IOB_ADDR_W'h4
`define TMR_COUNT_ADDR  `IOB_ADDR_W'h8
`define TMR_STATUS_ADDR `IOB_ADDR_W'hC

// CTRL bits
`define TMR_CTRL_EN_BIT  0
`define TMR_CTRL_AR_BIT  1
`define TMR_CTRL_IE_BIT  2

// STATUS bits
`define TMR_STATUS_EXP_BIT 0

`endif

//--- hdl/iob_timer_pkg.sv
`default_nettype none

`include "iob_timer_params.svh"

package iob_timer_pkg;

   // Native bus words
   typedef logic [`IOB_ADDR_W-1:0] addr_t;
   typedef logic [`IOB_DATA_W-1:0] data_t;
   typedef logic [`IOB_STRB_W-1:0] strb_t;

   // Bridge FSM states
   typedef enum logic [1:0] {
      IDLE       = 2'h0,
      WRITE      = 2'h1,
      READ       = 2'h2,
      W_RESPONSE = 2'h3
   } bridge_state_t;

endpackage

`default_nettype wire

//--- hdl/iob_timer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "iob_timer_params.svh"

module iob_timer_top (
   input  logic                     clk,
   input  logic                     rst,

   input  iob_timer_pkg::addr_t     s_axil_awaddr,
   input  logic                     s_axil_awvalid,
   output logic                     s_axil_awready,

   input  iob_timer_pkg::data_t     s_axil_wdata,
   input  iob_timer_pkg::strb_t     s_axil_wstrb,
   input  logic                     s_axil_wvalid,
   output logic                     s_axil_wready,

   output logic [`AXI_ID_W-1:0]     s_axil_bid,
   output logic [`AXI_RESP_W-1:0]   s_axil_bresp,
   output logic                     s_axil_bvalid,
   input  logic                     s_axil_bready,

   input  iob_timer_pkg::addr_t     s_axil_araddr,
   input  logic                     s_axil_arvalid,
   output logic                     s_axil_arready,

   output logic [`AXI_ID_W-1:0]     s_axil_rid,
   output iob_timer_pkg::data_t     s_axil_rdata,
   output logic [`AXI_RESP_W-1:0]   s_axil_rresp,
   output logic                     s_axil_rvalid,
   input  logic                     s_axil_rready,

   output logic                     irq
);

   import iob_timer_pkg::*;

   // Native bus between bridge and registers
   logic  valid;
   addr_t addr;
   data_t wdata;
   strb_t wstrb;
   data_t rdata;
   logic  ready;

   // Register block to counter
   logic  enable;
   logic  auto_reload;
   data_t load_value;
   logic  load;
   data_t count;
   logic  expire;

   axil2iob i_axil2iob (.*);

   timer_regs i_timer_regs (.*);

   timer_core i_timer_core (.*);

endmodule

`default_nettype wire

//--- hdl/timer_core.sv
`timescale 1ns/1ps
`default_nettype none

module timer_core (
   input  logic                 clk,
   input  logic                 rst,

   input  logic                 enable,
   input  logic                 auto_reload,
   input  iob_timer_pkg::data_t load_value,
   input  logic                 load,

   output iob_timer_pkg::data_t count,
   output logic                 expire
);

   import iob_timer_pkg::*;

   data_t count_nxt;
   logic  expire_nxt;

   always_comb begin
      count_nxt  = count;
      expire_nxt = 1'b0;

      if (load) begin
         count_nxt = load_value;
      end else if (enable && count != '0) begin
         if (count == data_t'(1)) begin
            // Reaching zero this cycle
            expire_nxt = 1'b1;
            count_nxt  = auto_reload ? load_value : '0;
         end else begin
            count_nxt = count - data_t'(1);
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count  <= '0;
         expire <= 1'b0;
      end else begin
         count  <= count_nxt;
         expire <= expire_nxt;
      end
   end

   // Count only rises on a load or a reload
   a_no_count_up: assert property (
      @(posedge clk) disable iff (rst)
      (!$past(load) && !expire) |-> (count <= $past(count))
   );

endmodule

`default_nettype wire

//--- hdl/timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "iob_timer_params.svh"

module timer_regs (
   input  logic                 clk,
   input  logic                 rst,

   // Native slave side
   input  logic                 valid,
   input  iob_timer_pkg::addr_t addr,
   input  iob_timer_pkg::data_t wdata,
   input  iob_timer_pkg::strb_t wstrb,
   output iob_timer_pkg::data_t rdata,
   output logic                 ready,

   // From timer core
   input  iob_timer_pkg::data_t count,
   input  logic                 expire,

   // To timer core
   output logic                 enable,
   output logic                 auto_reload,
   output iob_timer_pkg::data_t load_value,
   output logic                 load,

   output logic                 irq
);

   import iob_timer_pkg::*;

   logic [2:0] ctrl_q;
   data_t      load_q;
   logic       expired_q;

   logic  access;
   logic  wr;
   logic  rd;
   logic  wr_ctrl;
   logic  wr_load;
   logic  wr_status;
   data_t rd_word;

   // New access only while no answer is pending
   assign access = valid & ~ready;
   assign wr     = access & (|wstrb);
   assign rd     = access & ~(|wstrb);

   assign wr_ctrl   = wr && (addr == `TMR_CTRL_ADDR);
   assign wr_load   = wr && (addr == `TMR_LOAD_ADDR);
   assign wr_status = wr && (addr == `TMR_STATUS_ADDR);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl_q <= '0;
         load_q <= '0;
      end else begin
         if (wr_ctrl && wstrb[0]) begin
            ctrl_q <= wdata[2:0];
         end
         if (wr_load) begin
            for (int i = 0; i < `IOB_STRB_W; i++) begin
               if (wstrb[i]) begin
                  load_q[8*i +: 8] <= wdata[8*i +: 8];
               end
            end
         end
      end
   end

   // Sticky expiry, set wins over write-1-to-clear
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         expired_q <= 1'b0;
      end else if (expire) begin
         expired_q <= 1'b1;
      end else if (wr_status && wstrb[0] && wdata[`TMR_STATUS_EXP_BIT]) begin
         expired_q <= 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready <= 1'b0;
         load  <= 1'b0;
      end else begin
         ready <= access;
         load  <= wr_load;
      end
   end

   always_comb begin
      rd_word = '0;
      case (addr)
         `TMR_CTRL_ADDR:   rd_word[2:0] = ctrl_q;
         `TMR_LOAD_ADDR:   rd_word = load_q;
         `TMR_COUNT_ADDR:  rd_word = count;
         `TMR_STATUS_ADDR: rd_word[`TMR_STATUS_EXP_BIT] = expired_q;
         default:          rd_word = '0;
      endcase
   end

   // Read data stays put until the next read
   always_ff @(posedge clk) begin
      if (rd) begin
         rdata <= rd_word;
      end
   end

   assign enable      = ctrl_q[`TMR_CTRL_EN_BIT];
   assign auto_reload = ctrl_q[`TMR_CTRL_AR_BIT];
   assign load_value  = load_q;
   assign irq         = expired_q & ctrl_q[`TMR_CTRL_IE_BIT];

   // Bridge drops its request once answered
   a_request_dropped: assert property (
      @(posedge clk) disable iff (rst)
      ready |=> !valid
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module tb_iob_timer \
   --Mdir obj_dir -o tb_iob_timer \
   -f compile.f &&
./obj_dir/tb_iob_timer ||
{ echo "Simulation failed"; exit 1; }

//--- test/tb_iob_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "iob_timer_params.svh"

module tb_iob_timer;

   import iob_timer_pkg::*;

   typedef enum logic [2:0] {
      OP_WR,
      OP_RD,
      OP_RD_RANGE,
      OP_WAIT_IRQ,
      OP_IRQ
   } op_t;

   // Range reads use data as the low bound and expected as the high bound
   typedef struct packed {
      op_t   op;
      addr_t offset;
      data_t data;
      strb_t strb;
      data_t expected;
   } step_t;

   logic                   clk;
   logic                   rst;
   addr_t                  s_axil_awaddr;
   logic                   s_axil_awvalid;
   logic                   s_axil_awready;
   data_t                  s_axil_wdata;
   strb_t                  s_axil_wstrb;
   logic                   s_axil_wvalid;
   logic                   s_axil_wready;
   logic [`AXI_ID_W-1:0]   s_axil_bid;
   logic [`AXI_RESP_W-1:0] s_axil_bresp;
   logic                   s_axil_bvalid;
   logic                   s_axil_bready;
   addr_t                  s_axil_araddr;
   logic                   s_axil_arvalid;
   logic                   s_axil_arready;
   logic [`AXI_ID_W-1:0]   s_axil_rid;
   data_t                  s_axil_rdata;
   logic [`AXI_RESP_W-1:0] s_axil_rresp;
   logic                   s_axil_rvalid;
   logic                   s_axil_rready;
   logic                   irq;

   step_t       steps[$];
   int          step_idx;
   int          cycle_count = 0;
   int          timeout_limit;
   logic [31:0] lfsr_state;

   iob_timer_top i_iob_timer_top (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic end_with_failure();
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic report_timeout();
      bridge_state_t st;
      st = i_iob_timer_top.i_axil2iob.state;
      $display("Timeout: no progress after %0d cycles at step %0d, bridge in state %s",
               cycle_count, step_idx, st.name());
      end_with_failure();
   endtask

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_limit) begin
         report_timeout();
      end
   end

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic int take_bits(input int n);
      int value;
      int i;
      value = 0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
         value = (value << 1) | int'(lfsr_state[0]);
      end
      return value;
   endfunction

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("ERROR step %0d: %s = 0x%h, expected 0x%h", step_idx, name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_range(input string name, input data_t got, input data_t lo,
                              input data_t hi);
      if (got < lo || got > hi) begin
         $display("ERROR step %0d: %s = 0x%h, expected 0x%h to 0x%h",
                  step_idx, name, got, lo, hi);
         end_with_failure();
      end
   endtask

   // Every response must be OKAY
   task automatic check_resp(input string name, input logic [`AXI_RESP_W-1:0] got);
      if (got !== '0) begin
         $display("ERROR step %0d: %s = 0x%h, expected 0x0", step_idx, name, got);
         end_with_failure();
      end
   endtask

   // Only ID zero is ever used
   task automatic check_id(input string name, input logic [`AXI_ID_W-1:0] got);
      if (got !== '0) begin
         $display("ERROR step %0d: %s = 0x%h, expected 0x0", step_idx, name, got);
         end_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR step %0d: %s = 0x%h, expected 0x%h", step_idx, name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic axil_write(input addr_t a, input data_t d, input strb_t s);
      int hold;
      hold = take_bits(2);
      @(posedge clk);
      s_axil_awaddr  <= a;
      s_axil_awvalid <= 1'b1;
      s_axil_wdata   <= d;
      s_axil_wstrb   <= s;
      s_axil_wvalid  <= 1'b1;
      s_axil_bready  <= (hold == 0);
      @(posedge clk);
      while (!(s_axil_awready && s_axil_wready)) @(posedge clk);
      s_axil_awvalid <= 1'b0;
      s_axil_wvalid  <= 1'b0;
      @(posedge clk);
      while (!s_axil_bvalid) @(posedge clk);
      // Response must wait while bready is low
      if (hold > 0) begin
         repeat (hold) begin
            @(posedge clk);
            check_bit("s_axil_bvalid", s_axil_bvalid, 1'b1);
         end
         s_axil_bready <= 1'b1;
         @(posedge clk);
         check_bit("s_axil_bvalid", s_axil_bvalid, 1'b1);
      end
      check_resp("s_axil_bresp", s_axil_bresp);
      check_id("s_axil_bid", s_axil_bid);
      s_axil_bready <= 1'b0;
   endtask

   task automatic axil_read(input addr_t a, output data_t d);
      int hold;
      hold = take_bits(2);
      @(posedge clk);
      s_axil_araddr  <= a;
      s_axil_arvalid <= 1'b1;
      s_axil_rready  <= (hold == 0);
      @(posedge clk);
      while (!s_axil_arready) @(posedge clk);
      s_axil_arvalid <= 1'b0;
      check_bit("s_axil_rvalid", s_axil_rvalid, 1'b1);
      if (hold > 0) begin
         repeat (hold) begin
            @(posedge clk);
            check_bit("s_axil_rvalid", s_axil_rvalid, 1'b1);
         end
         s_axil_rready <= 1'b1;
         @(posedge clk);
         check_bit("s_axil_rvalid", s_axil_rvalid, 1'b1);
      end
      d = s_axil_rdata;
      check_resp("s_axil_rresp", s_axil_rresp);
      check_id("s_axil_rid", s_axil_rid);
      s_axil_rready <= 1'b0;
   endtask

   task automatic add_step(input op_t op, input addr_t offset, input data_t data,
                           input strb_t strb, input data_t expected);
      step_t s;
      s.op       = op;
      s.offset   = offset;
      s.data     = data;
      s.strb     = strb;
      s.expected = expected;
      steps.push_back(s);
   endtask

   task automatic build_table();
      // Register access and byte strobes
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'h0000_0006, 4'hF, '0);
      add_step(OP_RD, `TMR_CTRL_ADDR, '0, '0, 32'h0000_0006);
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'hFFFF_FFFF, 4'hE, '0);
      add_step(OP_RD, `TMR_CTRL_ADDR, '0, '0, 32'h0000_0006);
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'h0000_0000, 4'h1, '0);
      add_step(OP_RD, `TMR_CTRL_ADDR, '0, '0, 32'h0000_0000);
      add_step(OP_WR, `TMR_LOAD_ADDR, 32'h0000_0011, 4'hF, '0);
      add_step(OP_WR, `TMR_LOAD_ADDR, 32'hEEEE_22EE, 4'h2, '0);
      add_step(OP_RD, `TMR_LOAD_ADDR, '0, '0, 32'h0000_2211);
      add_step(OP_RD, `TMR_COUNT_ADDR, '0, '0, 32'h0000_2211);
      // COUNT is read-only, holes read as zero
      add_step(OP_WR, `TMR_COUNT_ADDR, 32'h0000_0055, 4'hF, '0);
      add_step(OP_RD, `TMR_COUNT_ADDR, '0, '0, 32'h0000_2211);
      add_step(OP_RD, 32'h0000_0010, '0, '0, 32'h0000_0000);
      add_step(OP_RD, 32'h0000_0FFC, '0, '0, 32'h0000_0000);
      add_step(OP_WR, `TMR_LOAD_ADDR, 32'h0000_0014, 4'hF, '0);
      add_step(OP_RD, `TMR_COUNT_ADDR, '0, '0, 32'h0000_0014);
      add_step(OP_RD, `TMR_COUNT_ADDR, '0, '0, 32'h0000_0014);
      // One-shot expiry and interrupt masking
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'h0000_0005, 4'hF, '0);
      add_step(OP_WAIT_IRQ, '0, '0, '0, '0);
      add_step(OP_RD, `TMR_STATUS_ADDR, '0, '0, 32'h0000_0001);
      add_step(OP_RD, `TMR_COUNT_ADDR, '0, '0, 32'h0000_0000);
      add_step(OP_IRQ, '0, '0, '0, 32'h0000_0001);
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'h0000_0001, 4'hF, '0);
      add_step(OP_IRQ, '0, '0, '0, 32'h0000_0000);
      add_step(OP_RD, `TMR_STATUS_ADDR, '0, '0, 32'h0000_0001);
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'h0000_0005, 4'hF, '0);
      add_step(OP_IRQ, '0, '0, '0, 32'h0000_0001);
      add_step(OP_WR, `TMR_STATUS_ADDR, 32'h0000_0001, 4'h1, '0);
      add_step(OP_IRQ, '0, '0, '0, 32'h0000_0000);
      add_step(OP_RD, `TMR_STATUS_ADDR, '0, '0, 32'h0000_0000);
      // Auto-reload keeps expiring
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'h0000_0000, 4'hF, '0);
      add_step(OP_WR, `TMR_LOAD_ADDR, 32'h0000_0028, 4'hF, '0);
      add_step(OP_WR, `TMR_CTRL_ADDR, 32'h0000_0007, 4'hF, '0);
      add_step(OP_WAIT_IRQ, '0, '0, '0, '0);
      add_step(OP_WR, `TMR_STATUS_ADDR, 32'h0000_0001, 4'h1, '0);
      add_step(OP_IRQ, '0, '0, '0, 32'h0000_0000);
      add_step(OP_RD_RANGE, `TMR_COUNT_ADDR, 32'h0000_0001, '0, 32'h0000_0028);
      add_step(OP_WAIT_IRQ, '0, '0, '0, '0);
      add_step(OP_RD, `TMR_STATUS_ADDR, '0, '0, 32'h0000_0001);
      add_step(OP_RD_RANGE, `TMR_COUNT_ADDR, 32'h0000_0001, '0, 32'h0000_0028);
   endtask

   // Largest value the LOAD register holds over the table
   function automatic int max_load_value();
      int    i;
      int    b;
      data_t load_reg;
      data_t best;
      load_reg = '0;
      best     = '0;
      for (i = 0; i < steps.size(); i++) begin
         if (steps[i].op == OP_WR && steps[i].offset == `TMR_LOAD_ADDR) begin
            for (b = 0; b < `IOB_STRB_W; b++) begin
               if (steps[i].strb[b]) begin
                  load_reg[8*b +: 8] = steps[i].data[8*b +: 8];
               end
            end
            if (load_reg > best) begin
               best = load_reg;
            end
         end
      end
      return int'(best);
   endfunction

   task automatic run_step(input step_t s);
      data_t got;
      case (s.op)
         OP_WR: begin
            axil_write(s.offset, s.data, s.strb);
         end
         OP_RD: begin
            axil_read(s.offset, got);
            check_data("s_axil_rdata", got, s.expected);
         end
         OP_RD_RANGE: begin
            axil_read(s.offset, got);
            check_range("s_axil_rdata", got, s.data, s.expected);
         end
         OP_WAIT_IRQ: begin
            @(posedge clk);
            while (!irq) @(posedge clk);
         end
         default: begin
            @(posedge clk);
            check_bit("irq", irq, s.expected[0]);
         end
      endcase
   endtask

   initial begin
      rst            <= 1'b1;
      s_axil_awaddr  <= '0;
      s_axil_awvalid <= 1'b0;
      s_axil_wdata   <= '0;
      s_axil_wstrb   <= '0;
      s_axil_wvalid  <= 1'b0;
      s_axil_bready  <= 1'b0;
      s_axil_araddr  <= '0;
      s_axil_arvalid <= 1'b0;
      s_axil_rready  <= 1'b0;
      lfsr_state = 32'd92286;
      step_idx = 0;
      build_table();
      timeout_limit = steps.size() * 64 + max_load_value() + 100;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      for (step_idx = 0; step_idx < steps.size(); step_idx++) begin
         run_step(steps[step_idx]);
      end
      @(posedge clk);
      $display("%0d steps in %0d cycles", steps.size(), cycle_count);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire
